// ==== compile.f ====
dbg_pkg.sv
dbg_dmi_ctrl.sv
dbg_hart_ctrl.sv
dbg_sba_apb.sv
dbg_mem_apb.sv
debug_system.sv
tb_debug_system.sv

// ==== tb_debug_system.sv ====
module tb_debug_system import dbg_pkg::*; ();

  localparam int unsigned NrHarts    = 4;
  localparam int unsigned DmiTimeout = 50;
  localparam int unsigned ApbTimeout = 20;
  localparam int unsigned PollLimit  = 50;

  logic               clk_i;
  logic               rst_ni;
  dmi_req_t           dmi_req;
  logic               dmi_req_valid;
  logic               dmi_req_ready;
  dmi_resp_t          dmi_resp;
  logic               dmi_resp_valid;
  logic               dmi_resp_ready;
  logic [NrHarts-1:0] debug_req;
  apb_req_t           sba_req;
  apb_resp_t          sba_resp;
  apb_req_t           hart_req;
  apb_resp_t          hart_resp;

  int unsigned err_cnt;
  int unsigned chk_cnt;
  logic [31:0] lfsr_q;
  dmi_data_t   exp_q[$];
  dmi_data_t   cmp_exp;

  // shadow of the debug module state
  dmi_data_t          sh_data0;
  logic               sh_dmactive;
  logic               sh_haltreq;
  hart_idx_t          sh_hartsel;
  logic [NrHarts-1:0] sh_halted;
  logic               sh_busyerr;
  logic               sh_rdonaddr;
  logic               sh_rdondata;
  logic               sh_inflight;
  logic [2:0]         sh_sberr;
  apb_addr_t          sh_sbaddr;
  dmi_data_t          sh_sbdata;

  // system bus memory model
  dmi_data_t   mem [0:255];
  logic        in_access;
  logic        acc_ready;
  int unsigned wait_cnt;
  logic        done_pend;
  logic        pend_err;
  logic        pend_read;
  dmi_data_t   pend_rdata;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  debug_system #(.NrHarts(NrHarts)) u_debug_system (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_req_i        (dmi_req),
    .dmi_req_valid_i  (dmi_req_valid),
    .dmi_req_ready_o  (dmi_req_ready),
    .dmi_resp_o       (dmi_resp),
    .dmi_resp_valid_o (dmi_resp_valid),
    .dmi_resp_ready_i (dmi_resp_ready),
    .debug_req_o      (debug_req),
    .sba_apb_req_o    (sba_req),
    .sba_apb_resp_i   (sba_resp),
    .hart_apb_req_i   (hart_req),
    .hart_apb_resp_o  (hart_resp)
  );

  // fibonacci lfsr with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic dmi_data_t ref_dmi_read(input dmi_addr_t addr);
    dmi_data_t v;
    v = '0;
    case (addr)
      AddrData0:     v = sh_data0;
      AddrDmcontrol: v = {sh_haltreq, 1'b0, 4'b0, sh_hartsel, 15'b0, sh_dmactive};
      AddrDmstatus: begin
        v[3:0] = 4'd2;
        v[8]   = |sh_halted;
        v[9]   = &sh_halted;
        v[10]  = |(~sh_halted);
        v[11]  = &(~sh_halted);
      end
      AddrSbcs: begin
        v[22]    = sh_busyerr;
        v[21]    = sh_inflight;
        v[20]    = sh_rdonaddr;
        v[19:17] = 3'd2;
        v[15]    = sh_rdondata;
        v[14:12] = sh_sberr;
      end
      AddrSbaddress0: v = sh_sbaddr;
      AddrSbdata0:    v = sh_sbdata;
      default:        v = '0;
    endcase
    return v;
  endfunction

  function automatic void shadow_write(input dmi_addr_t addr, input dmi_data_t d);
    case (addr)
      AddrData0: sh_data0 = d;
      AddrDmcontrol: begin
        sh_dmactive = d[0];
        sh_hartsel  = d[25:16];
        sh_haltreq  = d[31];
      end
      AddrSbcs: begin
        sh_rdonaddr = d[20];
        sh_rdondata = d[15];
        sh_sberr    = sh_sberr & ~d[14:12];
        if (d[22]) begin
          sh_busyerr = 1'b0;
        end
      end
      AddrSbaddress0: begin
        if (sh_rdonaddr && sh_inflight) begin
          sh_busyerr = 1'b1;
        end else begin
          sh_sbaddr = d;
          if (sh_rdonaddr) begin
            sh_inflight = 1'b1;
          end
        end
      end
      AddrSbdata0: begin
        if (sh_inflight) begin
          sh_busyerr = 1'b1;
        end else begin
          sh_sbdata   = d;
          sh_inflight = 1'b1;
        end
      end
      default: ;
    endcase
  endfunction

  function automatic void shadow_read(input dmi_addr_t addr);
    if (addr == AddrSbdata0 && sh_rdondata) begin
      if (sh_inflight) begin
        sh_busyerr = 1'b1;
      end else begin
        sh_inflight = 1'b1;
      end
    end
  endfunction

  task automatic check_val(input dmi_data_t got, input dmi_data_t exp, input string what);
    chk_cnt++;
    assert (got === exp) else begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic dmi_xfer(input dmi_op_e op, input dmi_addr_t addr, input dmi_data_t wdata,
                          output dmi_data_t rdata);
    int unsigned t;
    @(posedge clk_i);
    #1;
    dmi_req.addr  = addr;
    dmi_req.op    = op;
    dmi_req.data  = wdata;
    dmi_req_valid = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!dmi_req_ready) begin
      t++;
      if (t > DmiTimeout) abort_run("DMI request was never accepted");
      @(negedge clk_i);
    end
    // handshake happens on the coming edge
    if (op == dmi_read) begin
      exp_q.push_back(ref_dmi_read(addr));
      shadow_read(addr);
    end else begin
      exp_q.push_back('0);
      shadow_write(addr, wdata);
    end
    @(posedge clk_i);
    #1;
    dmi_req_valid = 1'b0;
    t = 0;
    @(negedge clk_i);
    while (!dmi_resp_valid) begin
      t++;
      if (t > DmiTimeout) abort_run("DMI response never arrived");
      @(negedge clk_i);
    end
    // the response belongs in the cycle right after the handshake
    check_val(32'(t), 32'h0, "dmi response latency");
    rdata = dmi_resp.data;
  endtask

  task automatic dmi_write_reg(input dmi_addr_t addr, input dmi_data_t wdata);
    dmi_data_t unused;
    dmi_xfer(dmi_write, addr, wdata, unused);
  endtask

  task automatic dmi_read_reg(input dmi_addr_t addr, output dmi_data_t rdata);
    dmi_xfer(dmi_read, addr, '0, rdata);
  endtask

  task automatic hart_xfer(input logic wr, input logic [7:0] off, input dmi_data_t wdata,
                           output dmi_data_t rdata, output logic err);
    int unsigned t;
    @(posedge clk_i);
    #1;
    hart_req.paddr   = {24'h0, off};
    hart_req.pwrite  = wr;
    hart_req.pwdata  = wdata;
    hart_req.psel    = 1'b1;
    hart_req.penable = 1'b0;
    @(posedge clk_i);
    #1;
    hart_req.penable = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!hart_resp.pready) begin
      t++;
      if (t > ApbTimeout) abort_run("hart port never raised pready");
      @(negedge clk_i);
    end
    rdata = hart_resp.prdata;
    err   = hart_resp.pslverr;
    @(posedge clk_i);
    #1;
    hart_req.psel    = 1'b0;
    hart_req.penable = 1'b0;
    if (wr && !err) begin
      case (off)
        MemHalted: if (wdata[9:0] < NrHarts) sh_halted[wdata[9:0]] = 1'b1;
        MemResuming: if (wdata[9:0] < NrHarts) sh_halted[wdata[9:0]] = 1'b0;
        MemData0: sh_data0 = wdata;
        default: ;
      endcase
    end
    @(negedge clk_i);
  endtask

  task automatic hart_write(input logic [7:0] off, input dmi_data_t wdata);
    dmi_data_t unused;
    logic      err;
    hart_xfer(1'b1, off, wdata, unused, err);
    check_val(32'(err), 32'h0, "pslverr on hart write");
  endtask

  task automatic hart_read(input logic [7:0] off, output dmi_data_t rdata);
    logic err;
    hart_xfer(1'b0, off, '0, rdata, err);
    check_val(32'(err), 32'h0, "pslverr on hart read");
  endtask

  task automatic sb_wait_idle();
    dmi_data_t   v;
    int unsigned n;
    n = 0;
    dmi_read_reg(AddrSbcs, v);
    while (v[21]) begin
      n++;
      if (n > PollLimit) abort_run("sbbusy never cleared");
      dmi_read_reg(AddrSbcs, v);
    end
  endtask

  // answers the system bus master with random wait states
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      // done reaches sbcs and sbdata0 one cycle after the access edge
      if (done_pend) begin
        sh_inflight = 1'b0;
        if (pend_err) begin
          sh_sberr = 3'd7;
        end else if (pend_read) begin
          sh_sbdata = pend_rdata;
        end
        done_pend = 1'b0;
      end
      if (in_access && acc_ready) begin
        // access phase with pready ended on this edge
        if (!sba_resp.pslverr && sba_req.pwrite) begin
          mem[sba_req.paddr[9:2]] = sba_req.pwdata;
        end
        pend_err       = sba_resp.pslverr;
        pend_read      = !sba_req.pwrite;
        pend_rdata     = sba_resp.prdata;
        done_pend      = 1'b1;
        in_access      = 1'b0;
        sba_resp.pready = 1'b0;
      end else if (in_access) begin
        // wait_cnt access cycles go by with pready low
        sba_resp.pready = (wait_cnt == 0);
        if (wait_cnt > 0) begin
          wait_cnt--;
        end
      end else if (sba_req.psel && !sba_req.penable) begin
        check_val(32'(sba_req.pstrb), 32'hf, "pstrb on system bus");
        in_access        = 1'b1;
        wait_cnt         = take_bits(2);
        sba_resp.pready  = 1'b0;
        sba_resp.pslverr = (sba_req.paddr >= 32'h8000_0000);
        sba_resp.prdata  = sba_resp.pslverr ? '0 : mem[sba_req.paddr[9:2]];
      end
      acc_ready = sba_req.penable && sba_resp.pready;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && dmi_resp_valid && dmi_resp_ready) begin
      assert (exp_q.size() > 0) else begin
        $display("DMI response came without an outstanding request at time %0t", $time);
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        cmp_exp = exp_q.pop_front();
        check_val(dmi_resp.data, cmp_exp, "dmi response data");
        check_val(32'(dmi_resp.resp), 32'h0, "dmi response code");
      end
    end
  end

  initial begin
    dmi_data_t   rd;
    dmi_data_t   wd;
    dmi_data_t   tmp;
    apb_addr_t   a;
    logic        herr;
    err_cnt = 0;
    chk_cnt = 0;
    lfsr_q  = 32'h428ff8dd;
    rst_ni         = 1'b0;
    dmi_req        = '0;
    dmi_req_valid  = 1'b0;
    dmi_resp_ready = 1'b1;
    hart_req       = '0;
    sba_resp       = '0;
    {sh_dmactive, sh_haltreq, sh_busyerr, sh_rdonaddr, sh_rdondata, sh_inflight} = '0;
    sh_data0  = '0;
    sh_hartsel = '0;
    sh_halted = '0;
    sh_sberr  = '0;
    sh_sbaddr = '0;
    sh_sbdata = '0;
    in_access = 1'b0;
    acc_ready = 1'b0;
    done_pend = 1'b0;
    wait_cnt  = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {12'hc5a, 10'h0, i[7:0], 2'b00} ^ {i[7:0], 24'h0};
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // data0 from both sides
    wd = take_bits(32);
    dmi_write_reg(AddrData0, wd);
    dmi_read_reg(AddrData0, rd);
    check_val(rd, wd, "data0 over dmi");
    hart_read(MemData0, rd);
    check_val(rd, wd, "data0 on hart port");
    wd = take_bits(32);
    hart_write(MemData0, wd);
    dmi_read_reg(AddrData0, rd);
    check_val(rd, wd, "data0 written by hart");

    // halt hart 2
    dmi_write_reg(AddrDmcontrol, 32'h8002_0001);
    check_val(32'(debug_req), 32'h4, "debug_req after haltreq");
    hart_write(MemHalted, 32'd2);
    check_val(32'(debug_req), 32'h0, "debug_req after halted");
    dmi_read_reg(AddrDmstatus, rd);
    check_val(32'(rd[11:8]), 32'h5, "dmstatus summary after halt");

    // resume hart 2, then ask a running hart to resume
    dmi_write_reg(AddrDmcontrol, 32'h4002_0001);
    dmi_read_reg(AddrDmcontrol, rd);
    check_val(32'(rd[30]), 32'h0, "resumereq reads as zero");
    hart_read(MemFlags, rd);
    check_val(rd, 32'h4, "resume flag set");
    hart_write(MemResuming, 32'd2);
    hart_read(MemFlags, rd);
    check_val(rd, 32'h0, "resume flag cleared");
    dmi_read_reg(AddrDmstatus, rd);
    check_val(32'(rd[11:8]), 32'hc, "dmstatus summary after resume");
    dmi_write_reg(AddrDmcontrol, 32'h4001_0001);
    hart_read(MemFlags, rd);
    check_val(rd, 32'h0, "no flag for running hart");

    // system bus writes
    dmi_write_reg(AddrSbcs, 32'h0);
    for (int i = 0; i < 4; i++) begin
      tmp = take_bits(8);
      a   = {22'h0, tmp[7:0], 2'b00};
      wd  = take_bits(32);
      dmi_write_reg(AddrSbaddress0, a);
      dmi_write_reg(AddrSbdata0, wd);
      sb_wait_idle();
      check_val(mem[a[9:2]], wd, "memory after sb write");
    end

    // reads on address, then chained on data
    dmi_write_reg(AddrSbcs, 32'h0010_8000);
    for (int i = 0; i < 4; i++) begin
      tmp = take_bits(8);
      a   = {22'h0, tmp[7:0], 2'b00};
      wd  = mem[a[9:2]];
      dmi_write_reg(AddrSbaddress0, a);
      sb_wait_idle();
      // new word so the chained read has to fetch it
      mem[a[9:2]] = take_bits(32);
      dmi_read_reg(AddrSbdata0, rd);
      check_val(rd, wd, "sb read on address");
      sb_wait_idle();
      dmi_read_reg(AddrSbdata0, rd);
      check_val(rd, mem[a[9:2]], "sb chained read on data");
      sb_wait_idle();
    end

    // bus error and its clear
    dmi_write_reg(AddrSbcs, 32'h0010_0000);
    dmi_write_reg(AddrSbaddress0, 32'h8000_0000);
    sb_wait_idle();
    dmi_read_reg(AddrSbcs, rd);
    check_val(32'(rd[14:12]), 32'h7, "sberror after bus error");
    dmi_write_reg(AddrSbcs, 32'h0000_7000);
    dmi_read_reg(AddrSbcs, rd);
    check_val(32'(rd[14:12]), 32'h0, "sberror after clear");

    // second write while the first is still in flight
    dmi_write_reg(AddrSbaddress0, 32'h40);
    wd = take_bits(32);
    dmi_write_reg(AddrSbdata0, wd);
    dmi_write_reg(AddrSbdata0, take_bits(32));
    sb_wait_idle();
    check_val(mem[16], wd, "memory keeps the first write");
    dmi_read_reg(AddrSbcs, rd);
    check_val(32'(rd[22]), 32'h1, "sbbusyerror set");
    dmi_write_reg(AddrSbcs, 32'h0040_0000);
    dmi_read_reg(AddrSbcs, rd);
    check_val(32'(rd[22]), 32'h0, "sbbusyerror cleared");

    // unmapped registers and offsets
    dmi_read_reg(7'h20, rd);
    check_val(rd, 32'h0, "unknown dmi address");
    dmi_write_reg(7'h20, take_bits(32));
    dmi_read_reg(7'h20, rd);
    check_val(rd, 32'h0, "unknown dmi address after write");
    dmi_read_reg(7'h7f, rd);
    check_val(rd, 32'h0, "top dmi address");
    hart_xfer(1'b0, 8'h0c, '0, rd, herr);
    check_val(32'(herr), 32'h1, "pslverr on unmapped hart read");
    hart_xfer(1'b1, 8'h20, take_bits(32), rd, herr);
    check_val(32'(herr), 32'h1, "pslverr on unmapped hart write");

    // let the last response be compared
    @(posedge clk_i);
    assert (exp_q.size() == 0) else begin
      $display("%0d DMI responses never arrived", exp_q.size());
      err_cnt++;
    end
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== debug_system.sv ====
module debug_system import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dmi_req_t           dmi_req_i,
  input  logic               dmi_req_valid_i,
  output logic               dmi_req_ready_o,
  output dmi_resp_t          dmi_resp_o,
  output logic               dmi_resp_valid_o,
  input  logic               dmi_resp_ready_i,
  output logic [NrHarts-1:0] debug_req_o,
  output apb_req_t           sba_apb_req_o,
  input  apb_resp_t          sba_apb_resp_i,
  input  apb_req_t           hart_apb_req_i,
  output apb_resp_t          hart_apb_resp_o
);

  sba_job_t           sba_job;
  sba_done_t          sba_done;
  hart_evt_t          hart_evt;
  logic               data0_we;
  dmi_data_t          data0_wdata;
  dmi_data_t          data0_rdata;
  hart_idx_t          hartsel;
  logic               haltreq;
  logic               resumereq;
  logic [NrHarts-1:0] resume_flags;
  logic               halted_any;
  logic               halted_all;
  logic               running_any;
  logic               running_all;

  dbg_dmi_ctrl u_dmi_ctrl (
    .clk_i,
    .rst_ni,
    .dmi_req_i,
    .dmi_req_valid_i,
    .dmi_req_ready_o,
    .dmi_resp_o,
    .dmi_resp_valid_o,
    .dmi_resp_ready_i,
    .sba_job_o     (sba_job),
    .sba_done_i    (sba_done),
    .data0_we_o    (data0_we),
    .data0_o       (data0_wdata),
    .data0_i       (data0_rdata),
    .hartsel_o     (hartsel),
    .haltreq_o     (haltreq),
    .resumereq_o   (resumereq),
    .halted_any_i  (halted_any),
    .halted_all_i  (halted_all),
    .running_any_i (running_any),
    .running_all_i (running_all)
  );

  dbg_hart_ctrl #(.NrHarts(NrHarts)) u_hart_ctrl (
    .clk_i,
    .rst_ni,
    .hartsel_i      (hartsel),
    .haltreq_i      (haltreq),
    .resumereq_i    (resumereq),
    .hart_evt_i     (hart_evt),
    .debug_req_o,
    .resume_flags_o (resume_flags),
    .halted_any_o   (halted_any),
    .halted_all_o   (halted_all),
    .running_any_o  (running_any),
    .running_all_o  (running_all)
  );

  // system bus master
  dbg_sba_apb u_sba_apb (
    .clk_i,
    .rst_ni,
    .job_i      (sba_job),
    .done_o     (sba_done),
    .apb_req_o  (sba_apb_req_o),
    .apb_resp_i (sba_apb_resp_i)
  );

  // hart facing slave
  dbg_mem_apb #(.NrHarts(NrHarts)) u_mem_apb (
    .clk_i,
    .rst_ni,
    .apb_req_i      (hart_apb_req_i),
    .apb_resp_o     (hart_apb_resp_o),
    .hart_evt_o     (hart_evt),
    .data0_we_i     (data0_we),
    .data0_i        (data0_wdata),
    .data0_o        (data0_rdata),
    .resume_flags_i (resume_flags)
  );

endmodule

// ==== dbg_mem_apb.sv ====
module dbg_mem_apb import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  apb_req_t           apb_req_i,
  output apb_resp_t          apb_resp_o,
  output hart_evt_t          hart_evt_o,
  input  logic               data0_we_i,
  input  dmi_data_t          data0_i,
  output dmi_data_t          data0_o,
  input  logic [NrHarts-1:0] resume_flags_i
);

  logic [7:0] offset;
  logic       access;
  logic       wr;
  logic       hit_halted;
  logic       hit_resuming;
  logic       hit_flags;
  logic       hit_data0;
  logic       hit;
  dmi_data_t  data0_q;

  assign offset = apb_req_i.paddr[7:0];
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr     = access & apb_req_i.pwrite;

  assign hit_halted   = (offset == MemHalted);
  assign hit_resuming = (offset == MemResuming);
  assign hit_flags    = (offset == MemFlags);
  assign hit_data0    = (offset == MemData0);
  assign hit          = hit_halted | hit_resuming | hit_flags | hit_data0;

  // no wait states on the hart side
  assign apb_resp_o.pready  = 1'b1;
  assign apb_resp_o.pslverr = apb_req_i.psel & ~hit;

  always_comb begin
    apb_resp_o.prdata = '0;
    if (hit_flags) begin
      apb_resp_o.prdata = dmi_data_t'(resume_flags_i);
    end else if (hit_data0) begin
      apb_resp_o.prdata = data0_q;
    end
  end

  // hart number comes in the write data
  assign hart_evt_o.halted   = wr & hit_halted;
  assign hart_evt_o.resuming = wr & hit_resuming;
  assign hart_evt_o.idx      = apb_req_i.pwdata[9:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data0_q <= '0;
    end else if (data0_we_i) begin
      // debugger side wins a same-cycle clash
      data0_q <= data0_i;
    end else if (wr && hit_data0) begin
      data0_q <= apb_req_i.pwdata;
    end
  end

  assign data0_o = data0_q;

endmodule

// ==== dbg_sba_apb.sv ====
module dbg_sba_apb import dbg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  sba_job_t  job_i,
  output sba_done_t done_o,
  output apb_req_t  apb_req_o,
  input  apb_resp_t apb_resp_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } sba_state_e;

  sba_state_e state_q;
  sba_state_e state_d;
  sba_done_t  done_q;
  apb_addr_t  addr_q;
  dmi_data_t  wdata_q;
  logic       write_q;
  logic       xfer_end;

  // access phase finishes when the slave is ready
  assign xfer_end = (state_q == st_access) & apb_resp_i.pready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (job_i.valid) begin
          state_d = st_setup;
        end
      end
      st_setup: begin
        state_d = st_access;
      end
      st_access: begin
        if (apb_resp_i.pready) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      done_q  <= '0;
    end else begin
      state_q      <= state_d;
      done_q.valid <= xfer_end;
      if (xfer_end) begin
        done_q.err   <= apb_resp_i.pslverr;
        done_q.rdata <= apb_resp_i.prdata;
      end
    end
  end

  // job fields are held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && job_i.valid) begin
      addr_q  <= job_i.addr;
      wdata_q <= job_i.data;
      write_q <= job_i.write;
    end
  end

  assign apb_req_o.paddr   = addr_q;
  assign apb_req_o.psel    = (state_q != st_idle);
  assign apb_req_o.penable = (state_q == st_access);
  assign apb_req_o.pwrite  = write_q;
  assign apb_req_o.pwdata  = wdata_q;
  assign apb_req_o.pstrb   = 4'hf;

  assign done_o = done_q;

endmodule

// ==== dbg_hart_ctrl.sv ====
module dbg_hart_ctrl import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hart_idx_t          hartsel_i,
  input  logic               haltreq_i,
  input  logic               resumereq_i,
  input  hart_evt_t          hart_evt_i,
  output logic [NrHarts-1:0] debug_req_o,
  output logic [NrHarts-1:0] resume_flags_o,
  output logic               halted_any_o,
  output logic               halted_all_o,
  output logic               running_any_o,
  output logic               running_all_o
);

  logic [NrHarts-1:0] halted_q;
  logic [NrHarts-1:0] resume_q;
  logic [NrHarts-1:0] sel;
  logic [NrHarts-1:0] halt_evt;
  logic [NrHarts-1:0] resume_evt;

  // out of range hartsel matches no hart
  always_comb begin
    for (int i = 0; i < NrHarts; i++) begin
      sel[i]        = (hartsel_i == hart_idx_t'(i));
      halt_evt[i]   = hart_evt_i.halted & (hart_evt_i.idx == hart_idx_t'(i));
      resume_evt[i] = hart_evt_i.resuming & (hart_evt_i.idx == hart_idx_t'(i));
    end
  end

  // request stays up until the hart reports halted
  assign debug_req_o = {NrHarts{haltreq_i}} & sel & ~halted_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q <= '0;
      resume_q <= '0;
    end else begin
      for (int i = 0; i < NrHarts; i++) begin
        if (halt_evt[i]) begin
          halted_q[i] <= 1'b1;
        end
        // only a halted hart can be asked to resume
        if (resumereq_i && sel[i] && halted_q[i]) begin
          resume_q[i] <= 1'b1;
        end
        if (resume_evt[i]) begin
          halted_q[i] <= 1'b0;
          resume_q[i] <= 1'b0;
        end
      end
    end
  end

  assign resume_flags_o = resume_q;
  assign halted_any_o   = |halted_q;
  assign halted_all_o   = &halted_q;
  assign running_any_o  = |(~halted_q);
  assign running_all_o  = &(~halted_q);

endmodule

// ==== dbg_dmi_ctrl.sv ====
module dbg_dmi_ctrl import dbg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dmi_req_t  dmi_req_i,
  input  logic      dmi_req_valid_i,
  output logic      dmi_req_ready_o,
  output dmi_resp_t dmi_resp_o,
  output logic      dmi_resp_valid_o,
  input  logic      dmi_resp_ready_i,
  output sba_job_t  sba_job_o,
  input  sba_done_t sba_done_i,
  output logic      data0_we_o,
  output dmi_data_t data0_o,
  input  dmi_data_t data0_i,
  output hart_idx_t hartsel_o,
  output logic      haltreq_o,
  output logic      resumereq_o,
  input  logic      halted_any_i,
  input  logic      halted_all_i,
  input  logic      running_any_i,
  input  logic      running_all_i
);

  logic      init_q;
  logic      resp_valid_q;
  dmi_data_t resp_data_q;
  logic      req_hs;
  logic      wr_en;
  logic      rd_en;
  dmi_data_t rdata;
  dmi_data_t dmcontrol_rd;
  dmi_data_t dmstatus_rd;
  dmi_data_t sbcs_rd;

  logic      dmactive_q;
  logic      haltreq_q;
  logic      resumereq_q;
  hart_idx_t hartsel_q;

  logic      sbbusy_q;
  logic      sbbusyerror_q;
  logic      sbreadonaddr_q;
  logic      sbreadondata_q;
  logic      sb_read_q;
  logic [2:0] sberror_q;
  apb_addr_t sbaddress_q;
  dmi_data_t sbdata_q;

  logic      start_rd_addr;
  logic      start_rd_data;
  logic      start_wr;
  logic      start_any;
  logic      start_ok;

  // ready rises one cycle after reset and drops while a response waits
  assign dmi_req_ready_o = init_q & ~resp_valid_q;
  assign req_hs = dmi_req_valid_i & dmi_req_ready_o;
  assign wr_en  = req_hs & (dmi_req_i.op == dmi_write);
  assign rd_en  = req_hs & (dmi_req_i.op == dmi_read);

  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_o.data  = resp_data_q;
  assign dmi_resp_o.resp  = 2'b00;

  always_comb begin
    dmcontrol_rd = '0;
    dmcontrol_rd[DmcDmactive] = dmactive_q;
    dmcontrol_rd[DmcHartselLo +: 10] = hartsel_q;
    dmcontrol_rd[DmcHaltreq] = haltreq_q;

    dmstatus_rd = '0;
    dmstatus_rd[3:0] = DmVersion;
    dmstatus_rd[DmsAnyhalted]  = halted_any_i;
    dmstatus_rd[DmsAllhalted]  = halted_all_i;
    dmstatus_rd[DmsAnyrunning] = running_any_i;
    dmstatus_rd[DmsAllrunning] = running_all_i;

    sbcs_rd = '0;
    sbcs_rd[SbcsBusyerror]     = sbbusyerror_q;
    sbcs_rd[SbcsBusy]          = sbbusy_q;
    sbcs_rd[SbcsReadonaddr]    = sbreadonaddr_q;
    sbcs_rd[SbcsAccessLo +: 3] = SbAccess32;
    sbcs_rd[SbcsReadondata]    = sbreadondata_q;
    sbcs_rd[SbcsErrorLo +: 3]  = sberror_q;
  end

  always_comb begin
    case (dmi_req_i.addr)
      AddrData0:      rdata = data0_i;
      AddrDmcontrol:  rdata = dmcontrol_rd;
      AddrDmstatus:   rdata = dmstatus_rd;
      AddrSbcs:       rdata = sbcs_rd;
      AddrSbaddress0: rdata = sbaddress_q;
      AddrSbdata0:    rdata = sbdata_q;
      default:        rdata = '0;
    endcase
  end

  // accesses that would kick off a bus job
  assign start_rd_addr = wr_en & (dmi_req_i.addr == AddrSbaddress0) & sbreadonaddr_q;
  assign start_wr      = wr_en & (dmi_req_i.addr == AddrSbdata0);
  assign start_rd_data = rd_en & (dmi_req_i.addr == AddrSbdata0) & sbreadondata_q;
  assign start_any     = start_rd_addr | start_wr | start_rd_data;
  assign start_ok      = start_any & ~sbbusy_q;

  assign sba_job_o.valid = start_ok;
  assign sba_job_o.write = start_wr;
  assign sba_job_o.addr  = start_rd_addr ? dmi_req_i.data : sbaddress_q;
  assign sba_job_o.data  = dmi_req_i.data;

  assign data0_we_o  = wr_en & (dmi_req_i.addr == AddrData0);
  assign data0_o     = dmi_req_i.data;
  assign hartsel_o   = hartsel_q;
  assign haltreq_o   = haltreq_q;
  assign resumereq_o = resumereq_q;

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      resp_data_q <= rd_en ? rdata : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q         <= 1'b0;
      resp_valid_q   <= 1'b0;
      dmactive_q     <= 1'b0;
      haltreq_q      <= 1'b0;
      resumereq_q    <= 1'b0;
      hartsel_q      <= '0;
      sbbusy_q       <= 1'b0;
      sbbusyerror_q  <= 1'b0;
      sbreadonaddr_q <= 1'b0;
      sbreadondata_q <= 1'b0;
      sb_read_q      <= 1'b0;
      sberror_q      <= '0;
      sbaddress_q    <= '0;
      sbdata_q       <= '0;
    end else begin
      init_q <= 1'b1;
      if (req_hs) begin
        resp_valid_q <= 1'b1;
      end else if (dmi_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end

      // resumereq is issued a cycle late so it sees the new hartsel
      resumereq_q <= 1'b0;
      if (wr_en && dmi_req_i.addr == AddrDmcontrol) begin
        dmactive_q  <= dmi_req_i.data[DmcDmactive];
        hartsel_q   <= dmi_req_i.data[DmcHartselLo +: 10];
        haltreq_q   <= dmi_req_i.data[DmcHaltreq];
        resumereq_q <= dmi_req_i.data[DmcResumereq];
      end

      if (wr_en && dmi_req_i.addr == AddrSbcs) begin
        sbreadonaddr_q <= dmi_req_i.data[SbcsReadonaddr];
        sbreadondata_q <= dmi_req_i.data[SbcsReadondata];
        sberror_q      <= sberror_q & ~dmi_req_i.data[SbcsErrorLo +: 3];
        if (dmi_req_i.data[SbcsBusyerror]) begin
          sbbusyerror_q <= 1'b0;
        end
      end

      // a busy-time write to sbaddress0 that would start a read is dropped
      if (wr_en && dmi_req_i.addr == AddrSbaddress0 && !(start_rd_addr && sbbusy_q)) begin
        sbaddress_q <= dmi_req_i.data;
      end
      if (start_wr && !sbbusy_q) begin
        sbdata_q <= dmi_req_i.data;
      end

      if (start_ok) begin
        sbbusy_q  <= 1'b1;
        sb_read_q <= ~start_wr;
      end else if (start_any) begin
        sbbusyerror_q <= 1'b1;
      end

      if (sba_done_i.valid) begin
        sbbusy_q <= 1'b0;
        if (sba_done_i.err) begin
          sberror_q <= 3'd7;
        end else if (sb_read_q) begin
          sbdata_q <= sba_done_i.rdata;
        end
      end
    end
  end

endmodule

// ==== dbg_pkg.sv ====
package dbg_pkg;

  // widths with a meaning of their own
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_data_t;
  typedef logic [31:0] apb_addr_t;
  typedef logic [9:0]  hart_idx_t;

  typedef enum logic [1:0] {
    dmi_nop   = 2'd0,
    dmi_read  = 2'd1,
    dmi_write = 2'd2
  } dmi_op_e;

  typedef struct packed {
    dmi_addr_t addr;
    dmi_op_e   op;
    dmi_data_t data;
  } dmi_req_t;

  // resp code is always zero here
  typedef struct packed {
    dmi_data_t  data;
    logic [1:0] resp;
  } dmi_resp_t;

  typedef struct packed {
    apb_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    dmi_data_t  pwdata;
    logic [3:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    dmi_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_resp_t;

  // one system bus job and its completion
  typedef struct packed {
    logic      valid;
    logic      write;
    apb_addr_t addr;
    dmi_data_t data;
  } sba_job_t;

  typedef struct packed {
    logic      valid;
    logic      err;
    dmi_data_t rdata;
  } sba_done_t;

  typedef struct packed {
    logic      halted;
    logic      resuming;
    hart_idx_t idx;
  } hart_evt_t;

  // dmi register map
  localparam dmi_addr_t AddrData0      = 7'h04;
  localparam dmi_addr_t AddrDmcontrol  = 7'h10;
  localparam dmi_addr_t AddrDmstatus   = 7'h11;
  localparam dmi_addr_t AddrSbcs       = 7'h38;
  localparam dmi_addr_t AddrSbaddress0 = 7'h39;
  localparam dmi_addr_t AddrSbdata0    = 7'h3c;

  // hart side offsets
  localparam logic [7:0] MemHalted   = 8'h00;
  localparam logic [7:0] MemResuming = 8'h04;
  localparam logic [7:0] MemFlags    = 8'h08;
  localparam logic [7:0] MemData0    = 8'h10;

  localparam logic [3:0] DmVersion = 4'd2;
  localparam logic [2:0] SbAccess32 = 3'd2;

  // dmcontrol fields
  localparam int unsigned DmcDmactive  = 0;
  localparam int unsigned DmcHartselLo = 16;
  localparam int unsigned DmcResumereq = 30;
  localparam int unsigned DmcHaltreq   = 31;

  // dmstatus fields
  localparam int unsigned DmsAnyhalted  = 8;
  localparam int unsigned DmsAllhalted  = 9;
  localparam int unsigned DmsAnyrunning = 10;
  localparam int unsigned DmsAllrunning = 11;

  // sbcs fields
  localparam int unsigned SbcsBusyerror  = 22;
  localparam int unsigned SbcsBusy       = 21;
  localparam int unsigned SbcsReadonaddr = 20;
  localparam int unsigned SbcsAccessLo   = 17;
  localparam int unsigned SbcsReadondata = 15;
  localparam int unsigned SbcsErrorLo    = 12;

endpackage
